/* common/mandelCfg.svh */
`ifndef MANDEL_CFG_SVH
`define MANDEL_CFG_SVH

// fixed-point format is signed two's complement, 4 integer bits
`define MANDEL_WORD_W 36
`define MANDEL_FRAC_W 32

// bound on |z|^2, which is 4.0 in the fixed-point format
`define MANDEL_ESCAPE 36'sh4_0000_0000

// screen coordinate fields, x above y in the flat buffer address
`define VGA_X_W 10
`define VGA_Y_W 9

`endif

/* common/mandelPkg.sv */
`include "mandelCfg.svh"

package mandelPkg;

  // signed fixed-point word used for every complex component
  typedef logic signed [`MANDEL_WORD_W-1:0] fixedT;

  // screen position with x in the upper bits
  typedef struct packed {
    logic [`VGA_X_W-1:0] x;
    logic [`VGA_Y_W-1:0] y;
  } vgaPosT;

  // the same 19 bits seen as a buffer address or as an x/y pair
  typedef union packed {
    logic [`VGA_X_W+`VGA_Y_W-1:0] addr;
    vgaPosT                       pos;
  } vgaCoordT;

  // one pixel to iterate, scanner to processor
  typedef struct packed {
    fixedT    cx;
    fixedT    cy;
    vgaCoordT coord;
  } pixelReqT;

  // finished pixel, processor to writer
  typedef struct packed {
    logic [3:0] color;
    vgaCoordT   coord;
  } pixelResultT;

  // view window, step is the distance between neighbouring pixels
  typedef struct packed {
    fixedT minX;
    fixedT minY;
    fixedT step;
  } viewT;

endpackage

/* source/pixelScanner.sv */
`timescale 1ns/100ps

`include "mandelCfg.svh"

module pixelScanner #(
  parameter int screenWidth  = 640,
  parameter int screenHeight = 480
) (
  input  logic                clk,
  input  logic                reset,
  input  logic                start,
  input  mandelPkg::viewT     view,
  input  logic                procReady,
  output mandelPkg::pixelReqT pixelReq,
  output logic                pixelVal
);

  localparam logic [`VGA_X_W-1:0] lastX = `VGA_X_W'(screenWidth - 1);
  localparam logic [`VGA_Y_W-1:0] lastY = `VGA_Y_W'(screenHeight - 1);

  typedef enum logic {
    stIdle,
    stIssue
  } stateT;

  stateT state;

  logic [`VGA_X_W-1:0] xCnt;
  logic [`VGA_Y_W-1:0] yCnt;
  logic                lastCol;
  logic                lastRow;

  // view kept for the frame, coordinates built by accumulation
  mandelPkg::fixedT minX;
  mandelPkg::fixedT step;
  mandelPkg::fixedT cxAcc;
  mandelPkg::fixedT cyAcc;

  assign lastCol = (xCnt == lastX);
  assign lastRow = (yCnt == lastY);

  always_ff @(posedge clk) begin
    if (reset) begin
      state    <= stIdle;
      pixelVal <= 1'b0;
    end else begin
      case (state)
        stIdle: begin
          pixelVal <= 1'b0;
          // start only counts here, a running frame ignores it
          if (start) begin
            state <= stIssue;
          end
        end
        stIssue: begin
          if (pixelVal) begin
            // processor takes the pixel on this edge
            pixelVal <= 1'b0;
            if (lastCol && lastRow) begin
              state <= stIdle;
            end
          end else if (procReady) begin
            pixelVal <= 1'b1;
          end
        end
        default: begin
          state <= stIdle;
        end
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (state == stIdle && start) begin
      minX  <= view.minX;
      step  <= view.step;
      cxAcc <= view.minX;
      cyAcc <= view.minY;
      xCnt  <= '0;
      yCnt  <= '0;
    end else if (state == stIssue && pixelVal) begin
      if (lastCol) begin
        // row wrap, back to the left edge
        xCnt  <= '0;
        cxAcc <= minX;
        yCnt  <= yCnt + 1'b1;
        cyAcc <= cyAcc + step;
      end else begin
        xCnt  <= xCnt + 1'b1;
        cxAcc <= cxAcc + step;
      end
    end
  end

  // request is held stable until the strobe is taken
  always_comb begin
    pixelReq.cx          = cxAcc;
    pixelReq.cy          = cyAcc;
    pixelReq.coord.pos.x = xCnt;
    pixelReq.coord.pos.y = yCnt;
  end

  // the processor must still be waiting when the strobe arrives
  assert property (@(posedge clk) disable iff (reset) pixelVal |-> procReady);

endmodule

/* mandelbrotProcessor/mandelbrotProcessor.sv */
`timescale 1ns/100ps

`include "mandelCfg.svh"

module mandelbrotProcessor #(
  parameter int maxIterations = 512
) (
  input  logic                   clk,
  input  logic                   reset,
  input  logic                   pixelVal,
  input  mandelPkg::pixelReqT    pixelReq,
  output logic                   procReady,
  output mandelPkg::pixelResultT result,
  output logic                   resultVal
);

  localparam int cntW = $clog2(maxIterations + 1);
  localparam logic [cntW-1:0] iterLimit = cntW'(maxIterations);
  localparam logic signed [`MANDEL_WORD_W:0] escapeBound = `MANDEL_ESCAPE;

  typedef enum logic [1:0] {
    stInit,
    stWaiting,
    stProcessing
  } stateT;

  stateT state;

  mandelPkg::fixedT cx;
  mandelPkg::fixedT cy;
  mandelPkg::fixedT zr;
  mandelPkg::fixedT zi;
  logic [cntW-1:0]  iterCount;

  // full-width products before rescaling
  logic signed [2*`MANDEL_WORD_W-1:0] zrSqFull;
  logic signed [2*`MANDEL_WORD_W-1:0] ziSqFull;
  logic signed [2*`MANDEL_WORD_W-1:0] zrZiFull;

  mandelPkg::fixedT zrSq;
  mandelPkg::fixedT ziSq;
  mandelPkg::fixedT zrZi;
  mandelPkg::fixedT zrNext;
  mandelPkg::fixedT ziNext;

  // one extra bit so the magnitude sum cannot wrap
  logic signed [`MANDEL_WORD_W:0] zrSqExt;
  logic signed [`MANDEL_WORD_W:0] ziSqExt;
  logic signed [`MANDEL_WORD_W:0] magSq;
  logic                           escaped;
  logic                           atLimit;

  // floor(log2(n)) as a priority encoder, 0 maps to 0, capped at 15
  function automatic logic [3:0] log2Floor(input logic [cntW-1:0] n);
    logic [3:0] lg;
    lg = 4'd0;
    for (int i = 1; i < cntW; i++) begin
      if (n[i]) begin
        lg = (i > 15) ? 4'd15 : 4'(i);
      end
    end
    return lg;
  endfunction

  assign zrSqFull = zr * zr;
  assign ziSqFull = zi * zi;
  assign zrZiFull = zr * zi;

  // shift out the fraction bits of the second operand, keep the word
  assign zrSq = zrSqFull[`MANDEL_FRAC_W +: `MANDEL_WORD_W];
  assign ziSq = ziSqFull[`MANDEL_FRAC_W +: `MANDEL_WORD_W];
  assign zrZi = zrZiFull[`MANDEL_FRAC_W +: `MANDEL_WORD_W];

  // squares are shared between the update and the escape test
  assign zrNext = zrSq - ziSq + cx;
  assign ziNext = (zrZi <<< 1) + cy;

  assign zrSqExt = zrSq;
  assign ziSqExt = ziSq;
  assign magSq   = zrSqExt + ziSqExt;
  assign escaped = (magSq > escapeBound);
  assign atLimit = (iterCount == iterLimit);

  assign procReady = (state == stWaiting);

  always_ff @(posedge clk) begin
    if (reset) begin
      state     <= stInit;
      resultVal <= 1'b0;
    end else begin
      resultVal <= 1'b0;
      case (state)
        stInit: begin
          state <= stWaiting;
        end
        stWaiting: begin
          if (pixelVal) begin
            state <= stProcessing;
          end
        end
        stProcessing: begin
          if (atLimit || escaped) begin
            state     <= stWaiting;
            resultVal <= 1'b1;
          end
        end
        default: begin
          state <= stInit;
        end
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (state == stWaiting && pixelVal) begin
      cx           <= pixelReq.cx;
      cy           <= pixelReq.cy;
      zr           <= '0;
      zi           <= '0;
      iterCount    <= '0;
      result.coord <= pixelReq.coord;
    end else if (state == stProcessing) begin
      if (atLimit) begin
        // never escaped, dark pixel
        result.color <= 4'd0;
      end else if (escaped) begin
        result.color <= log2Floor(iterCount);
      end else begin
        zr        <= zrNext;
        zi        <= ziNext;
        iterCount <= iterCount + 1'b1;
      end
    end
  end

  assert property (@(posedge clk) disable iff (reset)
    resultVal |-> $past(state == stProcessing));

  assert property (@(posedge clk) disable iff (reset)
    (state == stProcessing) |-> (iterCount <= iterLimit));

endmodule

/* source/frameWriter.sv */
`timescale 1ns/100ps

`include "mandelCfg.svh"

module frameWriter #(
  parameter int screenWidth  = 640,
  parameter int screenHeight = 480
) (
  input  logic                                 clk,
  input  logic                                 reset,
  input  mandelPkg::pixelResultT               result,
  input  logic                                 resultVal,
  output logic                                 memWe,
  output logic [`VGA_X_W+`VGA_Y_W-1:0]         memAddr,
  output logic [3:0]                           memData,
  output logic                                 frameDone
);

  localparam int totalPixels = screenWidth * screenHeight;
  localparam int cntW = $clog2(totalPixels + 1);
  localparam logic [cntW-1:0] lastWrite = cntW'(totalPixels - 1);

  mandelPkg::vgaCoordT writeCoord;
  logic [cntW-1:0]     writeCount;

  always_ff @(posedge clk) begin
    if (reset) begin
      memWe      <= 1'b0;
      frameDone  <= 1'b0;
      writeCount <= '0;
    end else begin
      // no back-pressure, every result becomes a write
      memWe     <= resultVal;
      frameDone <= 1'b0;
      if (memWe) begin
        if (writeCount == lastWrite) begin
          // last pixel of the frame is on the bus now
          frameDone  <= 1'b1;
          writeCount <= '0;
        end else begin
          writeCount <= writeCount + 1'b1;
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (resultVal) begin
      writeCoord <= result.coord;
      memData    <= result.color;
    end
  end

  assign memAddr = writeCoord.addr;

  // coordinate produced by the scanner must land inside the screen
  assert property (@(posedge clk) disable iff (reset)
    memWe |-> (writeCoord.pos.x < screenWidth && writeCoord.pos.y < screenHeight));

endmodule

/* source/mandelbrotRenderer.sv */
`timescale 1ns/100ps

`include "mandelCfg.svh"

module mandelbrotRenderer #(
  parameter int screenWidth   = 640,
  parameter int screenHeight  = 480,
  parameter int maxIterations = 512
) (
  input  logic                         clk,
  input  logic                         reset,
  input  logic                         start,
  input  mandelPkg::viewT              view,
  output logic                         memWe,
  output logic [`VGA_X_W+`VGA_Y_W-1:0] memAddr,
  output logic [3:0]                   memData,
  output logic                         frameDone
);

  // decode to execute
  mandelPkg::pixelReqT    pixelReq;
  logic                   pixelVal;
  logic                   procReady;

  // execute to result
  mandelPkg::pixelResultT result;
  logic                   resultVal;

  pixelScanner #(
    .screenWidth (screenWidth),
    .screenHeight(screenHeight)
  ) scanner (
    .clk      (clk),
    .reset    (reset),
    .start    (start),
    .view     (view),
    .procReady(procReady),
    .pixelReq (pixelReq),
    .pixelVal (pixelVal)
  );

  mandelbrotProcessor #(
    .maxIterations(maxIterations)
  ) processor (
    .clk      (clk),
    .reset    (reset),
    .pixelVal (pixelVal),
    .pixelReq (pixelReq),
    .procReady(procReady),
    .result   (result),
    .resultVal(resultVal)
  );

  frameWriter #(
    .screenWidth (screenWidth),
    .screenHeight(screenHeight)
  ) writer (
    .clk      (clk),
    .reset    (reset),
    .result   (result),
    .resultVal(resultVal),
    .memWe    (memWe),
    .memAddr  (memAddr),
    .memData  (memData),
    .frameDone(frameDone)
  );

endmodule

/* tests/mandelModel.svh */
`ifndef MANDEL_MODEL_SVH
`define MANDEL_MODEL_SVH

// full signed product, shifted down by the fraction bits, kept to one word
function automatic mandelPkg::fixedT scaledProduct(input mandelPkg::fixedT a,
                                                   input mandelPkg::fixedT b);
  logic signed [2*`MANDEL_WORD_W-1:0] wideA;
  logic signed [2*`MANDEL_WORD_W-1:0] wideB;
  logic signed [2*`MANDEL_WORD_W-1:0] prod;
  wideA = {{`MANDEL_WORD_W{a[`MANDEL_WORD_W-1]}}, a};
  wideB = {{`MANDEL_WORD_W{b[`MANDEL_WORD_W-1]}}, b};
  prod  = (wideA * wideB) >>> `MANDEL_FRAC_W;
  return prod[`MANDEL_WORD_W-1:0];
endfunction

// halving count, so 0 and 1 both give 0
function automatic logic [3:0] floorLog2(input int n);
  int halves;
  int rest;
  halves = 0;
  rest   = n;
  while (rest > 1) begin
    rest = rest / 2;
    halves++;
  end
  if (halves > 15) begin
    halves = 15;
  end
  return 4'(halves);
endfunction

// color of one point, 0 if it is still bounded at the iteration limit
function automatic logic [3:0] modelColor(input mandelPkg::fixedT cx,
                                          input mandelPkg::fixedT cy,
                                          input int maxIter);
  mandelPkg::fixedT               zr;
  mandelPkg::fixedT               zi;
  mandelPkg::fixedT               zrSq;
  mandelPkg::fixedT               ziSq;
  mandelPkg::fixedT               zrZi;
  logic signed [`MANDEL_WORD_W:0] magSq;
  logic signed [`MANDEL_WORD_W:0] bound;
  zr    = '0;
  zi    = '0;
  bound = {1'b0, `MANDEL_ESCAPE};
  for (int n = 0; n < maxIter; n++) begin
    zrSq  = scaledProduct(zr, zr);
    ziSq  = scaledProduct(zi, zi);
    magSq = {zrSq[`MANDEL_WORD_W-1], zrSq} + {ziSq[`MANDEL_WORD_W-1], ziSq};
    if (magSq > bound) begin
      return floorLog2(n);
    end
    zrZi = scaledProduct(zr, zi);
    zr   = zrSq - ziSq + cx;
    zi   = zrZi + zrZi + cy;
  end
  return 4'd0;
endfunction

// expected result of screen position x, y in a view
function automatic mandelPkg::pixelResultT expectedPixel(input mandelPkg::viewT v,
                                                         input int x, input int y,
                                                         input int maxIter);
  mandelPkg::pixelResultT px;
  mandelPkg::fixedT       cx;
  mandelPkg::fixedT       cy;
  cx = v.minX + mandelPkg::fixedT'(x) * v.step;
  cy = v.minY + mandelPkg::fixedT'(y) * v.step;
  px.color       = modelColor(cx, cy, maxIter);
  px.coord.pos.x = `VGA_X_W'(x);
  px.coord.pos.y = `VGA_Y_W'(y);
  return px;
endfunction

`endif

/* tests/mandelbrotRendererTb.sv */
`timescale 1ns/100ps

`include "mandelCfg.svh"

module mandelbrotRendererTb;

  localparam int screenWidth   = 8;
  localparam int screenHeight  = 6;
  localparam int maxIterations = 64;
  localparam int totalPixels   = screenWidth * screenHeight;
  localparam int timeoutCycles = 200000;
  localparam int numRows       = 6;

  logic                         clk;
  logic                         reset;
  logic                         start;
  mandelPkg::viewT              view;
  logic                         memWe;
  logic [`VGA_X_W+`VGA_Y_W-1:0] memAddr;
  logic [3:0]                   memData;
  logic                         frameDone;

  // view table, a negative write index leaves that event out
  string           rowName     [numRows];
  mandelPkg::viewT rowView     [numRows];
  bit              rowAllInside[numRows];
  int              rowStartAt  [numRows];
  int              rowResetAt  [numRows];
  int              rowCount;
  mandelPkg::viewT otherView;

  `include "mandelModel.svh"

  mandelbrotRenderer #(
    .screenWidth  (screenWidth),
    .screenHeight (screenHeight),
    .maxIterations(maxIterations)
  ) DUT (
    .clk      (clk),
    .reset    (reset),
    .start    (start),
    .view     (view),
    .memWe    (memWe),
    .memAddr  (memAddr),
    .memData  (memData),
    .frameDone(frameDone)
  );

  always #20 clk = ~clk;

  function automatic mandelPkg::fixedT fixedFromMilli(input int milli);
    longint scaled;
    scaled = longint'(milli) * 64'sd4294967296 / 64'sd1000;
    return mandelPkg::fixedT'(scaled);
  endfunction

  task automatic addRow(input string name, input mandelPkg::fixedT minX,
                        input mandelPkg::fixedT minY, input mandelPkg::fixedT step,
                        input bit allInside, input int startAt, input int resetAt);
    rowName[rowCount]      = name;
    rowView[rowCount].minX = minX;
    rowView[rowCount].minY = minY;
    rowView[rowCount].step = step;
    rowAllInside[rowCount] = allInside;
    rowStartAt[rowCount]   = startAt;
    rowResetAt[rowCount]   = resetAt;
    rowCount++;
  endtask

  task automatic reportFailure(input string what);
    $display("%s", what);
    $display("Simulation failed");
    $fatal(1);
  endtask

  task automatic checkPixel(input string name, input int index,
                            input mandelPkg::pixelResultT expected,
                            input mandelPkg::pixelResultT actual);
    if (actual !== expected) begin
      reportFailure($sformatf("MISMATCH %s write %0d: expected %0d at %h, actual %0d at %h",
                              name, index, expected.color, expected.coord.addr,
                              actual.color, actual.coord.addr));
    end
  endtask

  task automatic checkFrame(input string name, input int expected, input int actual);
    if (actual != expected) begin
      reportFailure($sformatf("MISMATCH %s write count at frameDone: expected %0d, actual %0d",
                              name, expected, actual));
    end
  endtask

  task automatic watchQuiet(input string name, input int cycles);
    for (int i = 0; i < cycles; i++) begin
      @(negedge clk);
      if (memWe || frameDone) begin
        reportFailure($sformatf("%s: a write or frameDone appeared while the renderer was idle",
                                name));
      end
    end
  endtask

  task automatic resetMidFrame(input string name);
    @(posedge clk);
    #2;
    reset = 1'b1;
    for (int i = 0; i < 10; i++) begin
      @(posedge clk);
      @(negedge clk);
      if (memWe || frameDone) begin
        reportFailure($sformatf("%s: a write or frameDone appeared during reset", name));
      end
    end
    @(posedge clk);
    #2;
    reset = 1'b0;
    watchQuiet(name, 100);
  endtask

  task automatic runFrame(input int row);
    mandelPkg::pixelResultT expected;
    mandelPkg::pixelResultT actual;
    mandelPkg::viewT        startView;
    int                     writes;
    int                     cycles;
    bit                     done;
    bit                     prevWe;
    bit                     startNext;
    writes    = 0;
    cycles    = 0;
    done      = 1'b0;
    prevWe    = 1'b0;
    startNext = 1'b1;
    startView = rowView[row];
    while (!done) begin
      @(posedge clk);
      #2;
      start = startNext;
      if (startNext) begin
        view = startView;
      end
      startNext = 1'b0;
      @(negedge clk);
      cycles++;
      if (memWe) begin
        if (writes >= totalPixels) begin
          reportFailure($sformatf("%s: more writes than pixels on the screen", rowName[row]));
        end
        // raster order, x is the inner loop
        expected = expectedPixel(rowView[row], writes % screenWidth, writes / screenWidth,
                                 maxIterations);
        if (rowAllInside[row]) begin
          expected.color = 4'd0;
        end
        actual.color      = memData;
        actual.coord.addr = memAddr;
        checkPixel(rowName[row], writes, expected, actual);
        writes++;
        if (writes == rowStartAt[row]) begin
          // a second start while busy must not change the frame
          startNext = 1'b1;
          startView = otherView;
        end
        if (writes == rowResetAt[row]) begin
          resetMidFrame(rowName[row]);
          done = 1'b1;
        end
      end
      if (!done && frameDone) begin
        if (!prevWe) begin
          reportFailure($sformatf("%s: frameDone did not follow the last write directly",
                                  rowName[row]));
        end
        checkFrame(rowName[row], totalPixels, writes);
        done = 1'b1;
        watchQuiet(rowName[row], 200);
      end
      prevWe = memWe;
      if (!done && cycles >= timeoutCycles) begin
        reportFailure($sformatf("%s: timeout, frameDone never came after %0d writes",
                                rowName[row], writes));
      end
    end
  endtask

  initial begin
    clk      = 1'b0;
    reset    = 1'b1;
    start    = 1'b0;
    view     = '0;
    rowCount = 0;
    addRow("fullView", fixedFromMilli(-2000), fixedFromMilli(-1200), fixedFromMilli(400),
           1'b0, -1, -1);
    addRow("seahorseValley", fixedFromMilli(-760), fixedFromMilli(80), fixedFromMilli(5),
           1'b0, -1, -1);
    // step of 2^-20 around the origin, every point stays bounded
    addRow("originTiny", -36'sd16384, -36'sd12288, 36'sd4096, 1'b1, -1, -1);
    addRow("fullMidStart", fixedFromMilli(-2000), fixedFromMilli(-1200), fixedFromMilli(400),
           1'b0, 10, -1);
    addRow("seahorseReset", fixedFromMilli(-760), fixedFromMilli(80), fixedFromMilli(5),
           1'b0, -1, 20);
    addRow("fullAfterReset", fixedFromMilli(-2000), fixedFromMilli(-1200),
           fixedFromMilli(400), 1'b0, -1, -1);
    otherView = rowView[1];
    repeat (10) @(posedge clk);
    #2;
    reset = 1'b0;
    watchQuiet("afterReset", 20);
    for (int row = 0; row < rowCount; row++) begin
      runFrame(row);
    end
    $display("Simulation passed");
    $finish;
  end

endmodule

/* files.f */
+incdir+common
+incdir+tests
common/mandelPkg.sv
source/pixelScanner.sv
mandelbrotProcessor/mandelbrotProcessor.sv
source/frameWriter.sv
source/mandelbrotRenderer.sv
tests/mandelbrotRendererTb.sv

/* run.sh */
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -sv -j 0 \
  --top-module mandelbrotRendererTb \
  -Mdir build \
  -f files.f

./build/VmandelbrotRendererTb
